//--- Makefile
.PHONY: all lint clean

all: obj_dir/VtbCpu
	./obj_dir/VtbCpu | tee sim.log
	grep -q "Finished with no errors" sim.log

obj_dir/VtbCpu: list.f $(wildcard *.sv *.svh)
	verilator --binary --assert -f list.f --top-module tbCpu -o VtbCpu

lint:
	verilator --lint-only --timing --assert -f list.f --top-module tbCpu

clean:
	rm -rf obj_dir sim.log

//--- cpuControl.sv
`timescale 1ns/1ps
`default_nettype none

module cpuControl import cpuPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  decodedOp   op,
    input  logic [3:0] laneEn,
    output logic       imemRd,
    output logic       pcWen,
    output logic       regWen,
    output logic       dmemRd,
    output logic [3:0] dmemWen,
    output logic       halted
);

    typedef enum logic [2:0] {
        stFetch = 3'd0,
        stDecEx = 3'd1,
        stMem   = 3'd2,
        stWb    = 3'd3,
        stHalt  = 3'd4
    } stateT;

    stateT state;
    stateT nextState;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= stFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            stFetch: nextState = stDecEx;
            stDecEx: begin
                if (op.isHalt) begin
                    nextState = stHalt;
                end else if (op.isLoad || op.isStore) begin
                    nextState = stMem;     // Extra cycle for the data port
                end else begin
                    nextState = stWb;
                end
            end
            stMem:   nextState = stWb;
            stWb:    nextState = stFetch;
            stHalt:  nextState = stHalt;   // Left only through reset
            default: nextState = stFetch;
        endcase
    end

    // Strobes decode straight from the state
    assign imemRd  = (state == stFetch);
    assign dmemRd  = (state == stMem);
    assign dmemWen = (state == stMem && op.isStore) ? laneEn : 4'b0000;
    assign pcWen   = (state == stWb);
    assign regWen  = (state == stWb) && !(op.isStore || op.isBranch || op.noWriteback);
    assign halted  = (state == stHalt);

    // Catches a corrupted state register
    assert property (@(posedge clk) disable iff (!rst)
        state inside {stFetch, stDecEx, stMem, stWb, stHalt})
        else $error("cpuControl illegal state %0d", state);

    // Stores may only land in the memory cycle that follows decode
    assert property (@(posedge clk) disable iff (!rst)
        (dmemWen != 4'b0000) |-> ($past(state) == stDecEx && op.isStore))
        else $error("cpuControl write strobe outside memory cycle");

    // Fetch and data access share no cycle
    assert property (@(posedge clk) disable iff (!rst)
        !(imemRd && dmemRd))
        else $error("cpuControl fetch overlaps data read");

endmodule

`default_nettype wire

//--- cpuCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module cpuCore import cpuPkg::*, memPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`CPU_XLEN-1:0] imemData,
    input  logic [`CPU_XLEN-1:0] dmemRdata,
    output memAddrT              imemAddr,
    output logic                 imemRd,
    output dmemReq               dmemOut,
    output logic                 halted
);

    decodedOp             op;
    logic                 pcWen;
    logic                 regWen;
    logic                 dmemRd;
    logic [3:0]           dmemWen;
    logic [3:0]           laneEn;
    memAddrT              dmemAddr;
    logic [`CPU_XLEN-1:0] dmemWdata;

    cpuControl uControl (
        .clk     (clk),
        .rst     (rst),
        .op      (op),
        .laneEn  (laneEn),
        .imemRd  (imemRd),
        .pcWen   (pcWen),
        .regWen  (regWen),
        .dmemRd  (dmemRd),
        .dmemWen (dmemWen),
        .halted  (halted)
    );

    // Instruction word is held by the memory output register
    instrDecoder uDecoder (
        .instr (imemData),
        .op    (op)
    );

    cpuDatapath uDatapath (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .pcWen     (pcWen),
        .regWen    (regWen),
        .dmemRdata (dmemRdata),
        .imemAddr  (imemAddr),
        .dmemAddr  (dmemAddr),
        .dmemWdata (dmemWdata),
        .laneEn    (laneEn)
    );

    assign dmemOut = '{rd: dmemRd, byteEn: dmemWen, addr: dmemAddr, wdata: dmemWdata};

endmodule

`default_nettype wire

//--- cpuDatapath.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module cpuDatapath import cpuPkg::*, memPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  decodedOp             op,
    input  logic                 pcWen,
    input  logic                 regWen,
    input  logic [`CPU_XLEN-1:0] dmemRdata,
    output memAddrT              imemAddr,
    output memAddrT              dmemAddr,
    output logic [`CPU_XLEN-1:0] dmemWdata,
    output logic [3:0]           laneEn
);

    memAddrT pc;
    memAddrT pcPlus4;
    memAddrT brTarget;

    logic [`CPU_XLEN-1:0] rsVal1;
    logic [`CPU_XLEN-1:0] rsVal2;
    logic [`CPU_XLEN-1:0] aluB;
    logic [`CPU_XLEN-1:0] aluRes;
    logic [`CPU_XLEN-1:0] wbData;
    logic                 brTaken;

    regFile uRegFile (
        .clk    (clk),
        .rst    (rst),
        .rs1    (op.rs1),
        .rs2    (op.rs2),
        .rd     (op.rd),
        .wen    (regWen),
        .wdata  (wbData),
        .rdata1 (rsVal1),
        .rdata2 (rsVal2)
    );

    assign aluB = op.useImm ? op.imm : rsVal2;

    always_comb begin
        case (op.aluOp)
            aluAdd:   aluRes = rsVal1 + aluB;
            aluSub:   aluRes = rsVal1 - aluB;
            aluAnd:   aluRes = rsVal1 & aluB;
            aluOr:    aluRes = rsVal1 | aluB;
            aluXor:   aluRes = rsVal1 ^ aluB;
            aluPassB: aluRes = aluB;
            default:  aluRes = '0;
        endcase
    end

    // Branch offset is in words from the next instruction
    assign brTaken  = op.isBranch && (rsVal1 == rsVal2);
    assign pcPlus4  = pc + memAddrT'(4);
    assign brTarget = pcPlus4 + {op.imm[`CPU_XLEN-3:0], 2'b00};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc <= '0;
        end else if (pcWen) begin
            pc <= brTaken ? brTarget : pcPlus4;
        end
    end

    assign imemAddr = pc;
    assign dmemAddr = aluRes;   // Effective address from the ALU

    // Byte lanes and store data placement
    always_comb begin
        case (op.storeSize)
            sizeByte: begin
                laneEn    = 4'b0001 << aluRes[1:0];
                dmemWdata = {4{rsVal2[7:0]}};
            end
            sizeHalf: begin
                laneEn    = aluRes[1] ? 4'b1100 : 4'b0011;
                dmemWdata = {2{rsVal2[15:0]}};
            end
            sizeWord: begin
                laneEn    = 4'b1111;   // Low address bits ignored
                dmemWdata = rsVal2;
            end
            default: begin
                laneEn    = 4'b0000;
                dmemWdata = rsVal2;
            end
        endcase
    end

    // Load data arrives in the writeback cycle
    assign wbData = op.isLoad ? dmemRdata : aluRes;

    // PC only ever moves by whole words
    assert property (@(posedge clk) disable iff (!rst)
        imemAddr[1:0] == 2'b00)
        else $error("cpuDatapath fetch address %h not word aligned", imemAddr);

endmodule

`default_nettype wire

//--- cpuPkg.sv
`default_nettype none
`include "cpu_cfg.svh"

package cpuPkg;

    localparam int opcW  = 6;                      // Opcode field width
    localparam int regAw = $clog2(`CPU_NREGS);     // Register index width
    localparam int immW  = 14;                     // Raw immediate width

    typedef logic [regAw-1:0] regIdxT;

    // Instruction opcodes in bits 31 to 26
    typedef enum logic [opcW-1:0] {
        opNop  = 6'h00,
        opAdd  = 6'h01,
        opSub  = 6'h02,
        opAnd  = 6'h03,
        opOr   = 6'h04,
        opXor  = 6'h05,
        opAddi = 6'h06,
        opLw   = 6'h07,
        opSw   = 6'h08,
        opSh   = 6'h09,
        opSb   = 6'h0A,
        opBeq  = 6'h0B,
        opHalt = `CPU_OP_HALT
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd   = 3'd0,
        aluSub   = 3'd1,
        aluAnd   = 3'd2,
        aluOr    = 3'd3,
        aluXor   = 3'd4,
        aluPassB = 3'd5    // Second operand straight through
    } aluOpT;

    typedef enum logic [1:0] {
        sizeNone = 2'd0,
        sizeByte = 2'd1,
        sizeHalf = 2'd2,
        sizeWord = 2'd3
    } storeSizeT;

    // One instruction after decode
    typedef struct packed {
        regIdxT                rd;
        regIdxT                rs1;
        regIdxT                rs2;
        logic [`CPU_XLEN-1:0]  imm;          // Sign extended
        aluOpT                 aluOp;
        storeSizeT             storeSize;
        logic                  useImm;
        logic                  isLoad;
        logic                  isStore;
        logic                  isBranch;
        logic                  noWriteback;  // NOP, HALT, unknown opcodes
        logic                  isHalt;
    } decodedOp;

endpackage

`default_nettype wire

//--- cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Data path and byte address width
`define CPU_XLEN 32

// Architectural registers, r0 reads as zero
`define CPU_NREGS 16

// Memory depths in 32-bit words
`define CPU_IMEM_WORDS 256
`define CPU_DMEM_WORDS 256

// Opcode that parks the core until reset
`define CPU_OP_HALT 6'h3F

`endif

//--- instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module instrDecoder import cpuPkg::*; (
    input  logic [`CPU_XLEN-1:0] instr,
    output decodedOp             op
);

    logic [opcW-1:0] opcode;

    assign opcode = instr[31:26];

    always_comb begin
        op = '0;

        // Fixed field positions for every format
        op.rd  = instr[25:22];
        op.rs1 = instr[21:18];
        op.rs2 = instr[17:14];
        op.imm = {{(`CPU_XLEN-immW){instr[immW-1]}}, instr[immW-1:0]};

        op.aluOp     = aluPassB;
        op.storeSize = sizeNone;

        case (opcode)
            opAdd: op.aluOp = aluAdd;
            opSub: op.aluOp = aluSub;
            opAnd: op.aluOp = aluAnd;
            opOr:  op.aluOp = aluOr;
            opXor: op.aluOp = aluXor;
            opAddi: begin
                op.aluOp  = aluAdd;
                op.useImm = 1'b1;
            end
            opLw: begin
                op.aluOp  = aluAdd;   // rs1 plus offset
                op.useImm = 1'b1;
                op.isLoad = 1'b1;
            end
            opSw, opSh, opSb: begin
                op.aluOp   = aluAdd;
                op.useImm  = 1'b1;
                op.isStore = 1'b1;
                if (opcode == opSw) begin
                    op.storeSize = sizeWord;
                end else if (opcode == opSh) begin
                    op.storeSize = sizeHalf;
                end else begin
                    op.storeSize = sizeByte;
                end
            end
            opBeq: begin
                op.aluOp    = aluSub;
                op.isBranch = 1'b1;   // Compare done in the datapath
            end
            opHalt: begin
                op.isHalt      = 1'b1;
                op.noWriteback = 1'b1;
            end
            default: begin
                // NOP and any unassigned code
                op.noWriteback = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
cpuPkg.sv
memPkg.sv
cpuControl.sv
instrDecoder.sv
regFile.sv
cpuDatapath.sv
cpuCore.sv
tbCpu.sv

//--- memPkg.sv
`default_nettype none
`include "cpu_cfg.svh"

package memPkg;

    // Byte address on either memory port
    typedef logic [`CPU_XLEN-1:0] memAddrT;

    // Data memory request, one per memory cycle
    typedef struct packed {
        logic                  rd;       // Read strobe
        logic [3:0]            byteEn;   // Write strobes per byte lane
        memAddrT               addr;
        logic [`CPU_XLEN-1:0]  wdata;
    } dmemReq;

endpackage

`default_nettype wire

//--- regFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module regFile import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  regIdxT               rs1,
    input  regIdxT               rs2,
    input  regIdxT               rd,
    input  logic                 wen,
    input  logic [`CPU_XLEN-1:0] wdata,
    output logic [`CPU_XLEN-1:0] rdata1,
    output logic [`CPU_XLEN-1:0] rdata2
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != '0) begin   // Writes to r0 are dropped
            regs[rd] <= wdata;
        end
    end

    // Asynchronous reads
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    // Decoder must hand over a clean destination on every write
    assert property (@(posedge clk) disable iff (!rst)
        wen |-> !$isunknown(rd))
        else $error("regFile write with unknown destination");

endmodule

`default_nettype wire

//--- tbModel.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int progLen = 200;

logic [31:0] lfsr = 32'd33;
logic [31:0] imem [`CPU_IMEM_WORDS];
logic [31:0] dmemInit [`CPU_DMEM_WORDS];
logic [31:0] modelMem [`CPU_DMEM_WORDS];

// Expected trace filled before the core leaves reset
logic [31:0] expPc [$];
int          expKind [$];   // 0 plain, 1 memory access, 2 halt
logic [31:0] stAddr [$];
logic [3:0]  stBe [$];
logic [31:0] stData [$];

function automatic logic lfsrBit();
    logic outBit;
    outBit = lfsr[0];
    lfsr = lfsr >> 1;
    if (outBit) lfsr = lfsr ^ 32'h80200003;   // Taps 32, 22, 2, 1
    return outBit;
endfunction

function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsrBit()};
    return v;
endfunction

task automatic buildProgram();
    logic [5:0]  aluOps [5] = '{opAdd, opSub, opAnd, opOr, opXor};
    logic [5:0]  opc;
    logic [3:0]  kind;
    logic [3:0]  rd;
    logic [3:0]  rs1;
    logic [3:0]  rs2;
    logic [13:0] imm;
    for (int i = 0; i < progLen - 1; i++) begin
        kind = 4'(randBits(4));
        rd   = 4'(randBits(4));
        rs1  = 4'(randBits(4));
        rs2  = 4'(randBits(4));
        imm  = 14'(randBits(14));
        if (kind < 5) begin
            opc = aluOps[kind[2:0]];
        end else if (kind < 8) begin
            opc = opAddi;
        end else if (kind < 13) begin
            // Loads and stores address off r0
            opc = (kind < 10) ? opLw : (kind == 10) ? opSw : (kind == 11) ? opSh : opSb;
            rs1 = '0;
            imm = (kind < 10) ? 14'(randBits(8) << 2) : 14'(randBits(10));
        end else if (kind == 13 || i >= progLen - 5) begin
            opc = lfsrBit() ? 6'(opNop) : 6'(12 + randBits(5));   // NOP or undefined
        end else begin
            opc = opBeq;
            if (lfsrBit()) rs2 = rs1;   // Forces a taken branch
            imm = 14'(1 + randBits(2));
        end
        imem[i] = {opc, rd, rs1, rs2, imm};
    end
    imem[progLen-1] = {opHalt, 26'd0};
    for (int i = progLen; i < `CPU_IMEM_WORDS; i++) imem[i] = {opHalt, 26'(i)};
    for (int i = 0; i < `CPU_DMEM_WORDS; i++) begin
        dmemInit[i] = randBits(32);
        modelMem[i] = dmemInit[i];
    end
endtask

// Instruction level reference stepping one instruction per pass
task automatic runModel();
    logic [31:0] regs [16];
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] ea;
    logic [31:0] res;
    logic [31:0] wd;
    logic [5:0]  opc;
    logic [3:0]  be;
    logic        done;
    for (int r = 0; r < 16; r++) regs[r] = '0;
    pc = '0;
    done = 1'b0;
    while (!done && expPc.size() < progLen) begin
        ins = imem[pc[iAw+1:2]];
        opc = ins[31:26];
        a   = regs[ins[21:18]];
        b   = regs[ins[17:14]];
        imm = {{18{ins[13]}}, ins[13:0]};
        ea  = a + imm;
        be  = 4'b0000;
        expPc.push_back(pc);
        pc = pc + 4;
        case (opc)
            opAdd:   res = a + b;
            opSub:   res = a - b;
            opAnd:   res = a & b;
            opOr:    res = a | b;
            opXor:   res = a ^ b;
            opAddi:  res = ea;
            opLw:    res = modelMem[ea[dAw+1:2]];
            opSw:    be = 4'b1111;
            opSh:    be = ea[1] ? 4'b1100 : 4'b0011;
            opSb:    be = 4'b0001 << ea[1:0];
            default: res = '0;   // No register result
        endcase
        if (opc == opBeq && a == b) pc = pc + (imm << 2);
        if (opc inside {opAdd, opSub, opAnd, opOr, opXor, opAddi, opLw} && ins[25:22] != 0) begin
            regs[ins[25:22]] = res;
        end
        wd = (opc == opSb) ? {4{b[7:0]}} : (opc == opSh) ? {2{b[15:0]}} : b;
        if (be != 4'b0000) begin
            stAddr.push_back(ea);
            stBe.push_back(be);
            stData.push_back(wd);
            for (int k = 0; k < 4; k++) begin
                if (be[k]) modelMem[ea[dAw+1:2]][8*k +: 8] = wd[8*k +: 8];
            end
        end
        expKind.push_back((opc == opHalt) ? 2 : (be != 4'b0000 || opc == opLw) ? 1 : 0);
        done = (opc == opHalt);
    end
endtask

`endif

//--- tbCpu.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module tbCpu import cpuPkg::*, memPkg::*; ();

    localparam int clkPeriod = 8;
    localparam int iAw = $clog2(`CPU_IMEM_WORDS);
    localparam int dAw = $clog2(`CPU_DMEM_WORDS);

    logic                 clk;
    logic                 rst = 1'b0;
    logic [`CPU_XLEN-1:0] imemData = '0;
    logic [`CPU_XLEN-1:0] dmemRdata = '0;
    memAddrT              imemAddr;
    logic                 imemRd;
    dmemReq               dmemOut;
    logic                 halted;
    logic [dAw-1:0]       dIdx;
    logic [31:0]          dmem [`CPU_DMEM_WORDS];

    int errors = 0;
    int checks = 0;
    int cyc = 0;        // Cycles since the last fetch strobe
    int curKind = -1;   // Kind of the instruction in flight
    int tailCycles;

    `include "tbModel.svh"

    cpuCore u_dut (
        .clk       (clk),
        .rst       (rst),
        .imemData  (imemData),
        .dmemRdata (dmemRdata),
        .imemAddr  (imemAddr),
        .imemRd    (imemRd),
        .dmemOut   (dmemOut),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    assign dIdx = dmemOut.addr[dAw+1:2];

    // Both memories register their output and hold it between reads
    always @(posedge clk) begin
        if (rst !== 1'b1) begin
            for (int i = 0; i < `CPU_DMEM_WORDS; i++) dmem[i] <= dmemInit[i];
        end else begin
            if (imemRd) imemData <= imem[imemAddr[iAw+1:2]];
            if (dmemOut.rd) dmemRdata <= dmem[dIdx];
            for (int k = 0; k < 4; k++) begin
                if (dmemOut.byteEn[k]) dmem[dIdx][8*k +: 8] <= dmemOut.wdata[8*k +: 8];
            end
        end
    end

    task automatic compareValue(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic checkStore();
        logic [31:0] expAddr;
        logic [3:0]  expBe;
        logic [31:0] expData;
        logic [31:0] mask;
        assert (stAddr.size() > 0) else begin
            errors++;
            $display("Unexpected data memory write at address %h", dmemOut.addr);
        end
        if (stAddr.size() > 0) begin
            expAddr = stAddr.pop_front();
            expBe   = stBe.pop_front();
            expData = stData.pop_front();
            for (int k = 0; k < 4; k++) mask[8*k +: 8] = {8{expBe[k]}};
            compareValue("store address", expAddr, dmemOut.addr);
            compareValue("store byte enables", 32'(expBe), 32'(dmemOut.byteEn));
            compareValue("store data", expData & mask, dmemOut.wdata & mask);
            compareValue("store cycle", 2, cyc);
        end
    endtask

    // Called once per cycle at the falling edge
    task automatic checkCycle();
        cyc++;
        if (imemRd) begin
            if (curKind >= 0) compareValue("instruction cycles", (curKind == 1) ? 4 : 3, cyc);
            assert (expPc.size() > 0) else begin
                errors++;
                $display("Fetch from %h after the program should have halted", imemAddr);
            end
            if (expPc.size() > 0) begin
                compareValue("fetch address", expPc.pop_front(), imemAddr);
                curKind = expKind.pop_front();
            end
            cyc = 0;
        end
        compareValue("data read strobe", 32'(curKind == 1 && cyc == 2), 32'(dmemOut.rd));
        compareValue("halted", 32'(curKind == 2 && cyc >= 2), 32'(halted));
        if (dmemOut.byteEn != 4'b0000) checkStore();
    endtask

    initial begin
        buildProgram();
        runModel();
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        tailCycles = 0;
        while (tailCycles < 8) begin   // A few idle cycles after halt
            @(negedge clk);
            checkCycle();
            if (halted) tailCycles++;
        end
        assert (expPc.size() == 0 && stAddr.size() == 0) else begin
            errors++;
            $display("Core halted with %0d fetches and %0d stores still missing",
                     expPc.size(), stAddr.size());
        end
        for (int i = 0; i < `CPU_DMEM_WORDS; i++) compareValue("final memory", modelMem[i], dmem[i]);
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Worst case is four cycles per instruction
    initial begin
        #(progLen * 4 * clkPeriod + 400);
        $display("Timeout, the core did not halt within %0d ns", progLen * 4 * clkPeriod + 400);
        $display("Checks %0d, errors %0d", checks, errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire
